// ==== design/obj_video_pkg.sv ====
/*
 * Sprite engine video constants
 * Readout timing of the line buffer and layout of the pixel word
 */
package obj_video_pkg;

    // Readout pipeline delay in pixels
    localparam logic [8:0] PXL_DLY = 9'd8;

    // Column counter value held during blanking
    localparam logic [8:0] HOBJ_START = 9'hAA - PXL_DLY;
    // Offset of the flipped start, added to 0x1FF
    localparam logic [8:0] FLIP_START = 9'hC0 - HOBJ_START;

    // Pixel word is {prio[1:0], pal[5:0], colour[3:0]}
    localparam int PXL_W = 12;

    // Four 4-bit pixels per 16-bit ROM word
    localparam int PIX_PER_WORD = 4;

endpackage

// ==== design/obj_table_pkg.sv ====
/*
 * Object table layout
 * Table size, address split and field positions of a four-word entry
 */
package obj_table_pkg;

    localparam int OBJ_COUNT     = 128;
    localparam int WORDS_PER_OBJ = 4;
    localparam int OBJ_AW        = $clog2(OBJ_COUNT);
    localparam int WORD_AW       = $clog2(WORDS_PER_OBJ);
    // Entry index on top, word index below
    localparam int TBL_AW        = OBJ_AW + WORD_AW;

    // Top line value that terminates the table
    localparam logic [7:0] END_TOP = 8'hFF;

    // Word order inside an entry
    localparam int W_LINES  = 0;
    localparam int W_XPOS   = 1;
    localparam int W_OFFSET = 2;
    localparam int W_ATTR   = 3;

    // Word 0
    localparam int TOP_LSB   = 0;
    localparam int TOP_MSB   = 7;
    localparam int BOT_LSB   = 8;
    localparam int BOT_MSB   = 15;
    // Word 1
    localparam int XPOS_LSB  = 0;
    localparam int XPOS_MSB  = 8;
    localparam int WIDTH_LSB = 9;
    localparam int WIDTH_MSB = 14;
    localparam int HFLIP_BIT = 15;
    // Word 3
    localparam int PAL_LSB   = 0;
    localparam int PAL_MSB   = 5;
    localparam int BANK_LSB  = 8;
    localparam int BANK_MSB  = 11;
    localparam int PRIO_LSB  = 12;
    localparam int PRIO_MSB  = 13;

endpackage

// ==== design/obj_ram.sv ====
/*
 * Object table RAM
 * 512 x 16 memory, CPU port with byte strobes plus a read port for the scanner
 */
`timescale 1ns/1ps

module obj_ram (
    input  logic                             clk,
    // CPU side
    input  logic                             cpu_cs,
    input  logic [obj_table_pkg::TBL_AW-1:0] cpu_addr,
    input  logic [15:0]                      cpu_wdata,
    input  logic [1:0]                       dswn,
    output logic [15:0]                      cpu_rdata,
    // Scanner side
    input  logic [obj_table_pkg::TBL_AW-1:0] tbl_addr,
    output logic [15:0]                      tbl_data
);
    import obj_table_pkg::*;

    logic [15:0] mem [1 << TBL_AW];

    // Strobes are active low, one per byte
    always_ff @(posedge clk) begin
        if (cpu_cs && !dswn[0]) begin
            mem[cpu_addr][7:0] <= cpu_wdata[7:0];
        end
        if (cpu_cs && !dswn[1]) begin
            mem[cpu_addr][15:8] <= cpu_wdata[15:8];
        end
    end

    // Registered reads on both ports
    // Read during a write returns the old word
    always_ff @(posedge clk) begin
        cpu_rdata <= mem[cpu_addr];
    end

    always_ff @(posedge clk) begin
        tbl_data <= mem[tbl_addr];
    end

endmodule

// ==== design/obj_scan.sv ====
/*
 * Object table scanner
 * Walks the table once per line and sends a draw command for each sprite
 * that covers the line being prepared
 */
`timescale 1ns/1ps

module obj_scan (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             hstart,
    input  logic [8:0]                       vrender,
    // Table read port
    output logic [obj_table_pkg::TBL_AW-1:0] tbl_addr,
    input  logic [15:0]                      tbl_data,
    // Draw command
    output logic                             dr_start,
    input  logic                             dr_busy,
    output logic [8:0]                       dr_xpos,
    output logic [15:0]                      dr_offset,
    output logic [5:0]                       dr_width,
    output logic [3:0]                       dr_bank,
    output logic [1:0]                       dr_prio,
    output logic [5:0]                       dr_pal,
    output logic                             dr_hflip
);
    import obj_table_pkg::*;

    logic [8:0]        line;
    logic [OBJ_AW-1:0] obj_idx;
    // Step 0 sends word 0, step k+1 sees word k
    logic [2:0]        step;
    logic              active;
    logic              wait_draw;
    logic              hit;
    logic [7:0]        row;
    logic [7:0]        top;
    logic [7:0]        bottom;
    logic              last_obj;

    assign tbl_addr = {obj_idx, step[WORD_AW-1:0]};
    assign top      = tbl_data[TOP_MSB:TOP_LSB];
    assign bottom   = tbl_data[BOT_MSB:BOT_LSB];
    assign last_obj = obj_idx == OBJ_AW'(OBJ_COUNT - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            wait_draw <= 1'b0;
            dr_start  <= 1'b0;
            obj_idx   <= '0;
            step      <= '0;
        end else if (hstart) begin
            // New line, walk again from entry 0
            active    <= 1'b1;
            wait_draw <= 1'b0;
            dr_start  <= 1'b0;
            obj_idx   <= '0;
            step      <= '0;
            line      <= vrender;
        end else begin
            dr_start <= 1'b0;
            if (wait_draw) begin
                // Hit held until the drawer is free
                if (!dr_busy) begin
                    dr_start  <= 1'b1;
                    wait_draw <= 1'b0;
                    if (last_obj) begin
                        active <= 1'b0;
                    end
                    obj_idx <= obj_idx + 1'b1;
                    step    <= '0;
                end
            end else if (active) begin
                step <= step + 1'b1;
                case (step)
                    3'(W_LINES + 1): begin
                        if (top == END_TOP) begin
                            active <= 1'b0;
                        end
                        // Inside when top <= line < bottom
                        hit <= ({1'b0, top} <= line) && (line < {1'b0, bottom});
                        row <= line[7:0] - top;
                    end
                    3'(W_XPOS + 1): begin
                        dr_xpos  <= tbl_data[XPOS_MSB:XPOS_LSB];
                        dr_width <= tbl_data[WIDTH_MSB:WIDTH_LSB];
                        dr_hflip <= tbl_data[HFLIP_BIT];
                        // Zero width has nothing to fetch
                        if (tbl_data[WIDTH_MSB:WIDTH_LSB] == '0) begin
                            hit <= 1'b0;
                        end
                    end
                    3'(W_OFFSET + 1): begin
                        // Skip the rows above the current one
                        dr_offset <= tbl_data + 16'(row) * 16'(dr_width);
                    end
                    3'(W_ATTR + 1): begin
                        dr_pal  <= tbl_data[PAL_MSB:PAL_LSB];
                        dr_bank <= tbl_data[BANK_MSB:BANK_LSB];
                        dr_prio <= tbl_data[PRIO_MSB:PRIO_LSB];
                        if (hit) begin
                            wait_draw <= 1'b1;
                        end else begin
                            if (last_obj) begin
                                active <= 1'b0;
                            end
                            obj_idx <= obj_idx + 1'b1;
                            step    <= '0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== design/obj_draw.sv ====
/*
 * Sprite row drawer
 * Fetches one row from graphics ROM and writes the opaque pixels
 * into the line buffer, one pixel per cycle
 */
`timescale 1ns/1ps

module obj_draw (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             hstart,
    // Command from the scanner
    input  logic                             start,
    output logic                             busy,
    input  logic [8:0]                       xpos,
    input  logic [15:0]                      offset,
    input  logic [5:0]                       width,
    input  logic [3:0]                       bank,
    input  logic [1:0]                       prio,
    input  logic [5:0]                       pal,
    input  logic                             hflip,
    // Graphics ROM
    output logic                             obj_cs,
    output logic [19:0]                      obj_addr,
    input  logic                             obj_ok,
    input  logic [15:0]                      obj_data,
    // Line buffer write
    output logic                             buf_we,
    output logic [8:0]                       buf_addr,
    output logic [obj_video_pkg::PXL_W-1:0]  buf_data
);
    import obj_video_pkg::*;

    logic        writing;
    logic [5:0]  words_left;
    logic [1:0]  nib_cnt;
    logic [15:0] pix_word;
    logic [8:0]  col;
    logic        cur_hflip;
    logic [1:0]  cur_prio;
    logic [5:0]  cur_pal;

    always_ff @(posedge clk) begin
        if (reset || hstart) begin
            // Line start drops whatever row is in progress
            busy    <= 1'b0;
            obj_cs  <= 1'b0;
            writing <= 1'b0;
            buf_we  <= 1'b0;
        end else begin
            buf_we <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy       <= 1'b1;
                    obj_cs     <= 1'b1;
                    obj_addr   <= {bank, offset};
                    words_left <= width;
                    cur_hflip  <= hflip;
                    cur_prio   <= prio;
                    cur_pal    <= pal;
                    // Flipped rows run right to left and end at xpos
                    col <= hflip ? xpos + 9'(width) * 9'(PIX_PER_WORD) - 9'd1 : xpos;
                end
            end else if (obj_cs) begin
                // Hold request until the ROM answers
                if (obj_ok) begin
                    obj_cs   <= 1'b0;
                    writing  <= 1'b1;
                    pix_word <= obj_data;
                    nib_cnt  <= '0;
                end
            end else if (writing) begin
                // MSB nibble first, colour 0 is transparent
                buf_we   <= pix_word[15:12] != 4'd0;
                buf_addr <= col;
                buf_data <= {cur_prio, cur_pal, pix_word[15:12]};
                pix_word <= pix_word << 4;
                col      <= cur_hflip ? col - 9'd1 : col + 9'd1;
                nib_cnt  <= nib_cnt + 1'b1;
                if (nib_cnt == 2'(PIX_PER_WORD - 1)) begin
                    writing <= 1'b0;
                    if (words_left == 6'd1) begin
                        busy <= 1'b0;
                    end else begin
                        // Next word of the row, same bank
                        words_left     <= words_left - 1'b1;
                        obj_addr[15:0] <= obj_addr[15:0] + 1'b1;
                        obj_cs         <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== design/obj_line_buffer.sv ====
/*
 * Double line buffer
 * One bank is drawn while the other is read out at pixel rate
 * and cleared behind the read
 */
`timescale 1ns/1ps

module obj_line_buffer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             hstart,
    // Drawer side
    input  logic                             we,
    input  logic [8:0]                       wr_addr,
    input  logic [obj_video_pkg::PXL_W-1:0]  wr_data,
    // Readout side
    input  logic                             rd,
    input  logic [8:0]                       rd_addr,
    output logic [obj_video_pkg::PXL_W-1:0]  rd_data
);
    import obj_video_pkg::*;

    // Bank select is the top address bit
    logic [PXL_W-1:0] mem [1024];
    logic             bank_sel;

    // Swap roles at every line start
    always_ff @(posedge clk) begin
        if (reset) begin
            bank_sel <= 1'b0;
        end else if (hstart) begin
            bank_sel <= ~bank_sel;
        end
    end

    // Write and erase always land in different banks
    always_ff @(posedge clk) begin
        if (we) begin
            mem[{bank_sel, wr_addr}] <= wr_data;
        end
        if (rd) begin
            rd_data                   <= mem[{~bank_sel, rd_addr}];
            // Leave the location blank for the next draw
            mem[{~bank_sel, rd_addr}] <= '0;
        end
    end

endmodule

// ==== design/obj_engine.sv ====
/*
 * Sprite engine top
 * Table RAM, scanner, drawer and line buffer, plus the readout column counter
 */
`timescale 1ns/1ps

module obj_engine (
    input  logic                             clk,
    input  logic                             reset,
    // CPU port
    input  logic                             cpu_cs,
    input  logic [obj_table_pkg::TBL_AW-1:0] cpu_addr,
    input  logic [15:0]                      cpu_wdata,
    input  logic [1:0]                       dswn,
    output logic [15:0]                      cpu_rdata,
    // Graphics ROM
    output logic                             obj_cs,
    output logic [19:0]                      obj_addr,
    input  logic                             obj_ok,
    input  logic [15:0]                      obj_data,
    // Video timing
    input  logic                             hstart,
    input  logic                             lhbl,
    input  logic                             pxl_cen,
    input  logic [8:0]                       vrender,
    input  logic                             flip,
    output logic [obj_video_pkg::PXL_W-1:0]  pxl
);
    import obj_video_pkg::*;
    import obj_table_pkg::*;

    logic [TBL_AW-1:0] tbl_addr;
    logic [15:0]       tbl_data;

    logic              dr_start;
    logic              dr_busy;
    logic [8:0]        dr_xpos;
    logic [15:0]       dr_offset;
    logic [5:0]        dr_width;
    logic [3:0]        dr_bank;
    logic [1:0]        dr_prio;
    logic [5:0]        dr_pal;
    logic              dr_hflip;

    logic              buf_we;
    logic [8:0]        buf_addr;
    logic [PXL_W-1:0]  buf_data;

    // Readout column
    logic [8:0]        hobj;

    obj_ram u_ram (
        .clk       (clk),
        .cpu_cs    (cpu_cs),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .dswn      (dswn),
        .cpu_rdata (cpu_rdata),
        .tbl_addr  (tbl_addr),
        .tbl_data  (tbl_data)
    );

    obj_scan u_scan (
        .clk       (clk),
        .reset     (reset),
        .hstart    (hstart),
        .vrender   (vrender),
        .tbl_addr  (tbl_addr),
        .tbl_data  (tbl_data),
        .dr_start  (dr_start),
        .dr_busy   (dr_busy),
        .dr_xpos   (dr_xpos),
        .dr_offset (dr_offset),
        .dr_width  (dr_width),
        .dr_bank   (dr_bank),
        .dr_prio   (dr_prio),
        .dr_pal    (dr_pal),
        .dr_hflip  (dr_hflip)
    );

    obj_draw u_draw (
        .clk       (clk),
        .reset     (reset),
        .hstart    (hstart),
        .start     (dr_start),
        .busy      (dr_busy),
        .xpos      (dr_xpos),
        .offset    (dr_offset),
        .width     (dr_width),
        .bank      (dr_bank),
        .prio      (dr_prio),
        .pal       (dr_pal),
        .hflip     (dr_hflip),
        .obj_cs    (obj_cs),
        .obj_addr  (obj_addr),
        .obj_ok    (obj_ok),
        .obj_data  (obj_data),
        .buf_we    (buf_we),
        .buf_addr  (buf_addr),
        .buf_data  (buf_data)
    );

    // Blanking reloads the start, each visible pixel steps by one
    always_ff @(posedge clk) begin
        if (reset) begin
            hobj <= HOBJ_START;
        end else if (!lhbl) begin
            hobj <= flip ? 9'h1FF + FLIP_START : HOBJ_START;
        end else if (pxl_cen) begin
            hobj <= flip ? hobj - 9'd1 : hobj + 9'd1;
        end
    end

    // Reads only in the visible part so the first column survives blanking
    obj_line_buffer u_line (
        .clk       (clk),
        .reset     (reset),
        .hstart    (hstart),
        .we        (buf_we),
        .wr_addr   (buf_addr),
        .wr_data   (buf_data),
        .rd        (pxl_cen && lhbl),
        .rd_addr   (hobj),
        .rd_data   (pxl)
    );

endmodule

// ==== bench/obj_rom_model.sv ====
/*
 * Graphics ROM model
 * Each word reads as its low address bits XOR 0x5A5A and is acknowledged
 * after a pseudo-random wait of 0 to 7 cycles
 */
`timescale 1ns/1ps

module obj_rom_model (
    input  logic        clk,
    input  logic        reset,
    input  logic        obj_cs,
    input  logic [19:0] obj_addr,
    output logic        obj_ok,
    output logic [15:0] obj_data
);
    localparam logic [31:0] SEED = 32'd82;

    logic [31:0] lcg_state;
    logic [31:0] lcg_peek;
    logic        pending;
    logic [2:0]  delay;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    assign lcg_peek = lcg_next(lcg_state);

    always_ff @(posedge clk) begin
        if (reset) begin
            lcg_state <= SEED;
            pending   <= 1'b0;
            delay     <= '0;
            obj_ok    <= 1'b0;
            obj_data  <= '0;
        end else begin
            obj_ok <= 1'b0;
            if (!obj_cs) begin
                // Request withdrawn, forget it
                pending <= 1'b0;
            end else if (pending) begin
                if (delay == 3'd0) begin
                    obj_ok   <= 1'b1;
                    obj_data <= obj_addr[15:0] ^ 16'h5A5A;
                    pending  <= 1'b0;
                end else begin
                    delay <= delay - 3'd1;
                end
            end else if (!obj_ok) begin
                // New request, draw its wait
                pending   <= 1'b1;
                lcg_state <= lcg_peek;
                delay     <= lcg_peek[18:16];
            end
        end
    end

endmodule

// ==== bench/obj_engine_tb.sv ====
/*
 * Sprite engine testbench
 * Checks the CPU byte strobes, then runs a table of sprite cases and
 * compares every ROM fetch and every visible pixel of the readout
 * with a reference
 */
`timescale 1ns/1ps

module obj_engine_tb;
    import obj_video_pkg::*;
    import obj_table_pkg::*;

    localparam int NUM_CASES    = 5;
    localparam int OBJ_PER_CASE = 4;
    localparam int LINE_SLOTS   = 512;
    localparam int BLANK_SLOTS  = 192;
    localparam int LINE_CYCLES  = 2 * LINE_SLOTS;
    localparam int CLK_NS       = 4;
    // Three lines per case, warm-up counted as two more cases
    localparam int WATCHDOG_NS  = (NUM_CASES + 2) * 3 * LINE_CYCLES * CLK_NS;
    // No sprite ever covers this line
    localparam logic [8:0] OFF_LINE      = 9'h1F0;
    localparam logic [8:0] CPU_TEST_ADDR = 9'h1FD;

    logic                 clk;
    logic                 reset;
    logic                 cpu_cs;
    logic [TBL_AW-1:0]    cpu_addr;
    logic [15:0]          cpu_wdata;
    logic [1:0]           dswn;
    logic [15:0]          cpu_rdata;
    logic                 obj_cs;
    logic [19:0]          obj_addr;
    logic                 obj_ok;
    logic [15:0]          obj_data;
    logic                 hstart;
    logic                 lhbl;
    logic                 pxl_cen;
    logic [8:0]           vrender;
    logic                 flip;
    logic [PXL_W-1:0]     pxl;

    // Stimulus table, one entry is {word3, word2, word1, word0}
    logic [63:0]          case_obj [NUM_CASES][OBJ_PER_CASE];
    logic [8:0]           case_v [NUM_CASES];
    logic                 case_flip [NUM_CASES];
    string                case_name [NUM_CASES];
    logic [15:0]          cpu_data [4];
    logic [1:0]           cpu_strobe [4];
    logic [PXL_W-1:0]     exp_line [LINE_SLOTS];
    // ROM words the drawer should fetch on the case line, in order
    logic [19:0]          exp_fetch [$];
    int                   errors;
    int                   case_errors;
    int                   tests_run;
    int                   tests_failed;

    obj_engine uut (
        .clk       (clk),
        .reset     (reset),
        .cpu_cs    (cpu_cs),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .dswn      (dswn),
        .cpu_rdata (cpu_rdata),
        .obj_cs    (obj_cs),
        .obj_addr  (obj_addr),
        .obj_ok    (obj_ok),
        .obj_data  (obj_data),
        .hstart    (hstart),
        .lhbl      (lhbl),
        .pxl_cen   (pxl_cen),
        .vrender   (vrender),
        .flip      (flip),
        .pxl       (pxl)
    );

    obj_rom_model u_rom (
        .clk      (clk),
        .reset    (reset),
        .obj_cs   (obj_cs),
        .obj_addr (obj_addr),
        .obj_ok   (obj_ok),
        .obj_data (obj_data)
    );

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [63:0] make_entry(
        input logic [7:0]  top,
        input logic [7:0]  bot,
        input logic [8:0]  x,
        input logic [5:0]  width,
        input logic        hflip,
        input logic [15:0] base,
        input logic [5:0]  pal,
        input logic [3:0]  bank,
        input logic [1:0]  prio
    );
        logic [15:0] w0;
        logic [15:0] w1;
        logic [15:0] w3;
        w0 = '0;
        w1 = '0;
        w3 = '0;
        w0[TOP_MSB:TOP_LSB]     = top;
        w0[BOT_MSB:BOT_LSB]     = bot;
        w1[XPOS_MSB:XPOS_LSB]   = x;
        w1[WIDTH_MSB:WIDTH_LSB] = width;
        w1[HFLIP_BIT]           = hflip;
        w3[PAL_MSB:PAL_LSB]     = pal;
        w3[BANK_MSB:BANK_LSB]   = bank;
        w3[PRIO_MSB:PRIO_LSB]   = prio;
        return {w3, base, w1, w0};
    endfunction

    task automatic load_cases();
        for (int c = 0; c < NUM_CASES; c++) begin
            for (int k = 0; k < OBJ_PER_CASE; k++) begin
                case_obj[c][k] = make_entry(END_TOP, 8'h00, 9'h000, 6'd0, 1'b0, 16'h0000,
                                            6'h00, 4'h0, 2'd0);
            end
        end
        // Row holds a zero nibble
        case_name[0]   = "single sprite";
        case_v[0]      = 9'h025;
        case_flip[0]   = 1'b0;
        case_obj[0][0] = make_entry(8'h20, 8'h30, 9'h0B0, 6'd2, 1'b0, 16'h0100, 6'h15, 4'h3, 2'd2);
        // Last line of the sprite, drawn right to left
        case_name[1]   = "horizontal flip";
        case_v[1]      = 9'h047;
        case_flip[1]   = 1'b0;
        case_obj[1][0] = make_entry(8'h40, 8'h48, 9'h100, 6'd3, 1'b1, 16'h2222, 6'h3F, 4'hA, 2'd1);
        // Second entry is mostly transparent over the first
        case_name[2]   = "overlap";
        case_v[2]      = 9'h01C;
        case_flip[2]   = 1'b0;
        case_obj[2][0] = make_entry(8'h10, 8'h20, 9'h120, 6'd2, 1'b0, 16'h0040, 6'h01, 4'h0, 2'd0);
        case_obj[2][1] = make_entry(8'h18, 8'h28, 9'h124, 6'd2, 1'b0, 16'h5A50, 6'h02, 4'h5, 2'd3);
        // Above one sprite, on the bottom of another, a hit hidden after the end
        case_name[3]   = "outside lines and end of table";
        case_v[3]      = 9'h060;
        case_flip[3]   = 1'b0;
        case_obj[3][0] = make_entry(8'h70, 8'h80, 9'h140, 6'd2, 1'b0, 16'h0300, 6'h07, 4'h1, 2'd1);
        case_obj[3][1] = make_entry(8'h50, 8'h60, 9'h150, 6'd2, 1'b0, 16'h0400, 6'h08, 4'h2, 2'd2);
        case_obj[3][3] = make_entry(8'h00, 8'hF0, 9'h160, 6'd2, 1'b0, 16'h0500, 6'h09, 4'h3, 2'd3);
        // Columns only seen in flipped readout, one of them wrapping past 0
        case_name[4]   = "screen flip";
        case_v[4]      = 9'h033;
        case_flip[4]   = 1'b1;
        case_obj[4][0] = make_entry(8'h30, 8'h40, 9'h1F0, 6'd2, 1'b0, 16'h0777, 6'h2A, 4'h7, 2'd2);
        case_obj[4][1] = make_entry(8'h00, 8'h80, 9'h004, 6'd3, 1'b1, 16'hF00F, 6'h05, 4'hF, 2'd1);
        // Full word first, then each byte alone, then none
        cpu_data   = '{16'h1234, 16'hABCD, 16'h5678, 16'hFFFF};
        cpu_strobe = '{2'b00, 2'b10, 2'b01, 2'b11};
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, expected);
            errors++;
            case_errors++;
        end
    endtask

    task automatic report_case(input string name);
        tests_run++;
        if (case_errors == 0) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d mismatches", name, case_errors);
        end
    endtask

    task automatic cpu_write(input logic [8:0] addr, input logic [15:0] data,
                             input logic [1:0] strobe);
        @(negedge clk);
        cpu_cs    = 1'b1;
        cpu_addr  = addr;
        cpu_wdata = data;
        dswn      = strobe;
        @(negedge clk);
        cpu_cs = 1'b0;
        dswn   = 2'b11;
    endtask

    task automatic cpu_read(input logic [8:0] addr, output logic [15:0] data);
        @(negedge clk);
        cpu_addr = addr;
        @(negedge clk);
        data = cpu_rdata;
    endtask

    task automatic write_case(input int c);
        for (int k = 0; k < OBJ_PER_CASE; k++) begin
            for (int w = 0; w < WORDS_PER_OBJ; w++) begin
                cpu_write(TBL_AW'(k * WORDS_PER_OBJ + w), case_obj[c][k][16 * w +: 16], 2'b00);
            end
        end
    endtask

    task automatic clear_expected();
        for (int i = 0; i < LINE_SLOTS; i++) begin
            exp_line[i] = '0;
        end
    endtask

    // Reference line and ROM fetches from the ROM rule and the draw rule
    task automatic build_expected(input int c);
        logic [15:0] w0;
        logic [15:0] w1;
        logic [15:0] w3;
        logic [15:0] base;
        logic [15:0] addr;
        logic [15:0] data;
        logic [7:0]  top;
        logic [7:0]  bot;
        logic [7:0]  row;
        logic [8:0]  x;
        logic [8:0]  col;
        logic [5:0]  width;
        logic [3:0]  nib;
        int          pos;
        clear_expected();
        exp_fetch.delete();
        for (int k = 0; k < OBJ_PER_CASE; k++) begin
            {w3, base, w1, w0} = case_obj[c][k];
            top = w0[TOP_MSB:TOP_LSB];
            if (top == END_TOP) begin
                break;
            end
            bot   = w0[BOT_MSB:BOT_LSB];
            x     = w1[XPOS_MSB:XPOS_LSB];
            width = w1[WIDTH_MSB:WIDTH_LSB];
            row   = case_v[c][7:0] - top;
            if ({1'b0, top} <= case_v[c] && case_v[c] < {1'b0, bot} && width != 6'd0) begin
                for (int wi = 0; wi < int'(width); wi++) begin
                    addr = base + 16'(row) * 16'(width) + 16'(wi);
                    exp_fetch.push_back({w3[BANK_MSB:BANK_LSB], addr});
                    data = addr ^ 16'h5A5A;
                    for (int n = 0; n < PIX_PER_WORD; n++) begin
                        nib = data[15 - 4 * n -: 4];
                        pos = wi * PIX_PER_WORD + n;
                        if (w1[HFLIP_BIT]) begin
                            col = x + 9'(int'(width) * PIX_PER_WORD - 1 - pos);
                        end else begin
                            col = x + 9'(pos);
                        end
                        // Later entries overwrite, colour 0 leaves the column alone
                        if (nib != 4'd0) begin
                            exp_line[col] = {w3[PRIO_MSB:PRIO_LSB], w3[PAL_MSB:PAL_LSB], nib};
                        end
                    end
                end
            end
        end
    endtask

    // One video line, blanking first, pixel reads checked one cycle later
    // A blank line expects 0 in every column
    task automatic run_line(input logic [8:0] vline, input logic line_flip, input logic check,
                            input logic blank);
        logic [8:0]       rd_col;
        logic             rd_prev;
        logic [PXL_W-1:0] exp_pix;
        rd_col  = line_flip ? 9'h1FF + FLIP_START : HOBJ_START;
        rd_prev = 1'b0;
        for (int cyc = 0; cyc <= LINE_CYCLES; cyc++) begin
            @(negedge clk);
            if (rd_prev) begin
                if (check) begin
                    exp_pix = blank ? '0 : exp_line[rd_col];
                    check_value($sformatf("column %h", rd_col), 32'(pxl), 32'(exp_pix));
                end
                rd_col = line_flip ? rd_col - 9'd1 : rd_col + 9'd1;
            end
            // Extra last cycle is idle blanking
            hstart  = cyc == 0;
            vrender = vline;
            flip    = line_flip;
            lhbl    = cyc < LINE_CYCLES && cyc / 2 >= BLANK_SLOTS;
            pxl_cen = cyc[0];
            rd_prev = lhbl && pxl_cen;
        end
    endtask

    // Each ROM answer must match the next fetch of the reference
    always @(negedge clk) begin
        if (obj_cs && obj_ok) begin
            if (exp_fetch.size() == 0) begin
                $display("Unexpected ROM fetch at %0t from address %h", $time, obj_addr);
                errors++;
                case_errors++;
            end else begin
                check_value("rom fetch address", 32'(obj_addr), 32'(exp_fetch.pop_front()));
            end
        end
    end

    initial begin
        logic [15:0] ref_word;
        logic [15:0] got;
        clk          = 1'b0;
        reset        = 1'b1;
        cpu_cs       = 1'b0;
        cpu_addr     = '0;
        cpu_wdata    = '0;
        dswn         = 2'b11;
        hstart       = 1'b0;
        lhbl         = 1'b0;
        pxl_cen      = 1'b0;
        vrender      = '0;
        flip         = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        load_cases();
        repeat (8) @(negedge clk);
        reset = 1'b0;

        // CPU byte strobes with read-back
        case_errors = 0;
        ref_word    = '0;
        for (int i = 0; i < 4; i++) begin
            cpu_write(CPU_TEST_ADDR, cpu_data[i], cpu_strobe[i]);
            if (!cpu_strobe[i][0]) begin
                ref_word[7:0] = cpu_data[i][7:0];
            end
            if (!cpu_strobe[i][1]) begin
                ref_word[15:8] = cpu_data[i][15:8];
            end
            cpu_read(CPU_TEST_ADDR, got);
            check_value($sformatf("cpu word after dswn %b", cpu_strobe[i]), 32'(got),
                        32'(ref_word));
        end
        report_case("cpu byte strobes");

        // Empty table, then wipe both banks in both readout directions
        cpu_write('0, {8'h00, END_TOP}, 2'b00);
        run_line(OFF_LINE, 1'b0, 1'b0, 1'b1);
        run_line(OFF_LINE, 1'b0, 1'b0, 1'b1);
        run_line(OFF_LINE, 1'b1, 1'b0, 1'b1);
        run_line(OFF_LINE, 1'b1, 1'b0, 1'b1);

        for (int c = 0; c < NUM_CASES; c++) begin
            case_errors = 0;
            write_case(c);
            build_expected(c);
            // Bank shown here was drawn and read back in the previous case
            run_line(case_v[c], case_flip[c], 1'b1, 1'b1);
            check_value("rom fetches left over", 32'(exp_fetch.size()), 32'd0);
            run_line(OFF_LINE, case_flip[c], 1'b1, 1'b0);
            // Nothing drawn on the off line
            run_line(OFF_LINE, case_flip[c], 1'b1, 1'b1);
            report_case(case_name[c]);
        end

        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the run did not reach its end", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
design/obj_video_pkg.sv
design/obj_table_pkg.sv
design/obj_ram.sv
design/obj_scan.sv
design/obj_draw.sv
design/obj_line_buffer.sv
design/obj_engine.sv
bench/obj_rom_model.sv
bench/obj_engine_tb.sv

// ==== Makefile ====
SIM        := verilator
TOP        := obj_engine_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "Simulation gave no result"; exit 1; fi

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
